//--- logic/banana_frame_top.sv
`timescale 1ns/1ps

module banana_frame_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   frame_start,
    input  banana_pkg::coord_x_t   left_x,
    input  banana_pkg::coord_y_t   top_y,
    input  logic                   sliced,
    input  banana_pkg::rgb565_t    background,
    input  logic                   credit_return,
    output logic                   pix_valid,
    output banana_pkg::pixel_out_t pix,
    output logic                   busy
);

    banana_pkg::frame_cfg_t settings;
    banana_pkg::frame_cfg_t cfg;
    logic                   req_valid;
    banana_pkg::pixel_req_t req;
    logic                   span_valid;
    banana_pkg::span_t      span;
    logic                   span_last;
    logic                   pix_done;

    assign settings = '{left_x: left_x, top_y: top_y, sliced: sliced, background: background};
    assign pix_done = pix_valid && pix.last;

    frame_control u_frame_control (
        .clk           (clk),
        .arst_n        (arst_n),
        .frame_start   (frame_start),
        .settings      (settings),
        .credit_return (credit_return),
        .last_req      (req.last),
        .pix_done      (pix_done),
        .cfg           (cfg),
        .req_valid     (req_valid),
        .busy          (busy)
    );

    pixel_scanner u_pixel_scanner (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (req_valid),
        .req    (req)
    );

    banana_span_table u_span_table (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (req_valid),
        .req        (req),
        .cfg        (cfg),
        .span_valid (span_valid),
        .span       (span),
        .last       (span_last)
    );

    pixel_colorizer u_colorizer (
        .clk        (clk),
        .arst_n     (arst_n),
        .span_valid (span_valid),
        .span       (span),
        .last       (span_last),
        .background (cfg.background),
        .pix_valid  (pix_valid),
        .pix        (pix)
    );

endmodule

//--- logic/banana_pkg.sv
package banana_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry and flow control

    localparam int unsigned DISPLAY_W  = 96;
    localparam int unsigned DISPLAY_H  = 64;
    localparam int unsigned SPRITE_W   = 52;
    localparam int unsigned SPRITE_H   = 60;
    // Request to output pixel
    localparam int unsigned PIPE_DEPTH = 3;
    // Sink buffer depth
    localparam int unsigned CREDITS    = 4;

    ////////////////////////////////////////////////////////////
    // RGB565 palette

    localparam logic [15:0] COLOR_BLACK       = 16'b00000_000000_00000;
    localparam logic [15:0] COLOR_YELLOW      = 16'b11111_111111_00000;
    localparam logic [15:0] COLOR_DARK_YELLOW = 16'b11011_101100_00010;
    localparam logic [15:0] COLOR_PALE_YELLOW = 16'b11100_111000_10001;

    ////////////////////////////////////////////////////////////
    // Scalar types

    typedef logic [6:0]  coord_x_t;
    typedef logic [5:0]  coord_y_t;
    typedef logic [5:0]  offset_x_t;
    typedef logic [5:0]  offset_y_t;
    typedef logic [15:0] rgb565_t;
    typedef logic [2:0]  credit_t;

    // Row range, empty when lo > hi
    typedef struct packed {
        offset_y_t lo;
        offset_y_t hi;
    } band_t;

    localparam band_t BAND_NONE = '{lo: 6'd63, hi: 6'd0};

    typedef struct packed {
        coord_x_t left_x;
        coord_y_t top_y;
        logic     sliced;
        rgb565_t  background;
    } frame_cfg_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        logic     last;
    } pixel_req_t;

    typedef struct packed {
        logic      in_box;
        offset_y_t dy;
        band_t     outline;
        band_t     dark;
        band_t     yellow;
        band_t     cut;
        band_t     pale;
    } span_t;

    typedef struct packed {
        rgb565_t color;
        logic    last;
    } pixel_out_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN
    } frame_state_t;

endpackage

//--- logic/banana_span_table.sv
`timescale 1ns/1ps

module banana_span_table (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  banana_pkg::pixel_req_t req,
    input  banana_pkg::frame_cfg_t cfg,
    output logic                   span_valid,
    output banana_pkg::span_t      span,
    output logic                   last
);

    banana_pkg::coord_x_t  dx_full;
    banana_pkg::coord_y_t  dy_full;
    logic                  in_box_d;
    logic                  s1_valid;
    logic                  s1_last;
    logic                  s1_in_box;
    banana_pkg::offset_x_t s1_dx;
    banana_pkg::offset_y_t s1_dy;
    logic [4:0]            pair;
    banana_pkg::span_t     tbl;

    function automatic banana_pkg::band_t rng(input int lo, input int hi);
        banana_pkg::band_t b;
        b.lo = banana_pkg::offset_y_t'(lo);
        b.hi = banana_pkg::offset_y_t'(hi);
        return b;
    endfunction

    function automatic banana_pkg::band_t nil();
        return banana_pkg::BAND_NONE;
    endfunction

    function automatic banana_pkg::span_t pack(
        input banana_pkg::band_t outline,
        input banana_pkg::band_t dark,
        input banana_pkg::band_t yellow,
        input banana_pkg::band_t cut,
        input banana_pkg::band_t pale
    );
        banana_pkg::span_t s;
        s         = '0;
        s.outline = outline;
        s.dark    = dark;
        s.yellow  = yellow;
        s.cut     = cut;
        s.pale    = pale;
        return s;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stage 1: offset from the sprite corner

    assign dx_full  = req.x - cfg.left_x;
    assign dy_full  = req.y - cfg.top_y;
    assign in_box_d = (req.x >= cfg.left_x) && (req.y >= cfg.top_y)
                      && (dx_full < banana_pkg::SPRITE_W)
                      && (dy_full < banana_pkg::SPRITE_H);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s1_valid   <= 1'b0;
            span_valid <= 1'b0;
        end
        else
        begin
            s1_valid   <= in_valid;
            span_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_last   <= req.last;
        s1_in_box <= in_box_d;
        s1_dx     <= dx_full[5:0];
        s1_dy     <= dy_full;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2: band limits per column pair

    assign pair = s1_dx[5:1];

    always_comb
    begin
        // outline, dark, yellow, cut, pale
        case (pair)
            5'd0:  tbl = pack(rng(12,23), nil(), nil(), nil(), nil());
            5'd1:  tbl = pack(rng(7,28), rng(12,23), nil(), nil(), nil());
            5'd2:  tbl = pack(rng(0,33), rng(7,28), nil(), nil(), nil());
            5'd3:  tbl = pack(rng(0,39), rng(25,33), rng(7,24), nil(), nil());
            5'd4:  tbl = pack(rng(0,43), rng(33,39), rng(7,32), nil(), nil());
            5'd5:  tbl = pack(rng(7,47), rng(38,43), rng(12,37), nil(), nil());
            5'd6:  tbl = pack(rng(12,49), rng(43,47), rng(24,42), nil(), nil());
            5'd7:  tbl = pack(rng(24,51), rng(47,49), rng(26,46), nil(), nil());
            5'd8:  tbl = pack(rng(26,53), rng(50,51), rng(28,49), nil(), nil());
            5'd9:  tbl = pack(rng(28,53), rng(50,51), rng(30,49), nil(), nil());
            5'd10: tbl = pack(rng(30,55), rng(50,53), rng(32,49), nil(), nil());
            5'd11: tbl = pack(rng(32,55), rng(49,53), rng(34,48), nil(), nil());
            5'd12: tbl = pack(rng(32,57), rng(49,55), rng(34,48), nil(), nil());
            5'd13, 5'd14, 5'd15:
                tbl = pack(rng(34,59), rng(53,57), rng(36,52), nil(), nil());
            5'd16, 5'd17:
                tbl = pack(rng(32,55), rng(51,53), rng(34,50), nil(), nil());
            5'd18: tbl = pack(rng(30,53), rng(50,51), rng(32,49), nil(), nil());
            5'd19: tbl = pack(rng(28,53), rng(49,51), rng(30,48), nil(), nil());
            5'd20: tbl = pack(rng(26,51), rng(48,49), rng(28,47), nil(), nil());
            5'd21: tbl = pack(rng(26,49), rng(45,47), rng(28,44), nil(), nil());
            5'd22: tbl = pack(rng(24,47), rng(41,44), rng(26,40), nil(), nil());
            5'd23: tbl = pack(rng(24,44), rng(35,41), rng(26,34), nil(), nil());
            5'd24: tbl = pack(rng(26,41), rng(33,35), rng(30,32), nil(), nil());
            5'd25: tbl = pack(rng(30,35), nil(), nil(), nil(), nil());
            default: tbl = pack(nil(), nil(), nil(), nil(), nil());
        endcase

        // Cut section overrides the middle columns
        if (cfg.sliced)
        begin
            case (pair)
                5'd8:  tbl = pack(rng(26,27), nil(), rng(28,48), nil(), rng(45,48));
                5'd9:  tbl = pack(rng(28,53), nil(), rng(30,45), rng(46,51), rng(43,45));
                5'd10: tbl = pack(rng(30,55), rng(50,53), rng(32,49), rng(45,50), rng(43,51));
                5'd11: tbl = pack(rng(32,55), rng(49,53), rng(34,48), rng(44,47), rng(41,51));
                5'd12: tbl = pack(rng(32,57), rng(49,55), rng(34,48), rng(43,46), rng(40,49));
                5'd13: tbl = pack(rng(34,59), rng(53,57), rng(36,52), rng(41,44), rng(37,47));
                5'd14: tbl = pack(rng(34,59), rng(53,57), rng(36,52), rng(38,42), rng(37,45));
                5'd15: tbl = pack(rng(34,59), rng(53,57), rng(36,52), rng(37,40), rng(41,43));
                5'd16: tbl = pack(rng(32,55), rng(51,53), rng(34,50), rng(35,38), rng(39,41));
                5'd17: tbl = pack(rng(32,55), rng(51,53), rng(34,50), rng(0,35), rng(36,39));
                5'd18: tbl = pack(rng(30,53), rng(50,51), rng(32,49), rng(0,33), rng(34,36));
                5'd19: tbl = pack(rng(28,53), rng(49,51), rng(30,48), rng(0,30), rng(31,34));
                5'd20: tbl = pack(rng(26,51), rng(48,49), rng(28,47), nil(), rng(30,31));
                default: ;
            endcase
        end

        tbl.in_box = s1_in_box;
        tbl.dy     = s1_dy;
    end

    always_ff @(posedge clk)
    begin
        span <= tbl;
        last <= s1_last;
    end

endmodule

//--- logic/frame_control.sv
`timescale 1ns/1ps

module frame_control (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   frame_start,
    input  banana_pkg::frame_cfg_t settings,
    input  logic                   credit_return,
    input  logic                   last_req,
    input  logic                   pix_done,
    output banana_pkg::frame_cfg_t cfg,
    output logic                   req_valid,
    output logic                   busy
);

    banana_pkg::frame_state_t state_q;
    banana_pkg::frame_state_t state_d;
    banana_pkg::credit_t      credits_q;

    // A credit is reserved per request so nothing downstream stalls
    assign req_valid = (state_q == banana_pkg::SCAN) && (credits_q != '0);
    assign busy      = (state_q != banana_pkg::IDLE);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            banana_pkg::IDLE:
            begin
                if (frame_start)
                    state_d = banana_pkg::SCAN;
            end
            banana_pkg::SCAN:
            begin
                if (req_valid && last_req)
                    state_d = banana_pkg::DRAIN;
            end
            banana_pkg::DRAIN:
            begin
                // Wait for the final pixel to leave the pipe
                if (pix_done)
                    state_d = banana_pkg::IDLE;
            end
            default: state_d = banana_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q   <= banana_pkg::IDLE;
            credits_q <= banana_pkg::credit_t'(banana_pkg::CREDITS);
            cfg       <= '0;
        end
        else
        begin
            state_q   <= state_d;
            credits_q <= credits_q - banana_pkg::credit_t'(req_valid)
                                   + banana_pkg::credit_t'(credit_return);
            if ((state_q == banana_pkg::IDLE) && frame_start)
                cfg <= settings;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits_q <= banana_pkg::credit_t'(banana_pkg::CREDITS));

    // Last request shows up at the output a fixed time later
    a_last_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && last_req) |-> ##(banana_pkg::PIPE_DEPTH) pix_done);

endmodule

//--- logic/pixel_colorizer.sv
`timescale 1ns/1ps

module pixel_colorizer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   span_valid,
    input  banana_pkg::span_t      span,
    input  logic                   last,
    input  banana_pkg::rgb565_t    background,
    output logic                   pix_valid,
    output banana_pkg::pixel_out_t pix
);

    banana_pkg::rgb565_t color_d;

    function automatic logic in_band(
        input banana_pkg::band_t     b,
        input banana_pkg::offset_y_t dy
    );
        return (dy >= b.lo) && (dy <= b.hi);
    endfunction

    // First match wins
    always_comb
    begin
        if (!span.in_box)
            color_d = background;
        else if (in_band(span.cut, span.dy))
            color_d = background;
        else if (in_band(span.pale, span.dy))
            color_d = banana_pkg::COLOR_PALE_YELLOW;
        else if (in_band(span.yellow, span.dy))
            color_d = banana_pkg::COLOR_YELLOW;
        else if (in_band(span.dark, span.dy))
            color_d = banana_pkg::COLOR_DARK_YELLOW;
        else if (in_band(span.outline, span.dy))
            color_d = banana_pkg::COLOR_BLACK;
        else
            color_d = background;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pix_valid <= 1'b0;
        else
            pix_valid <= span_valid;
    end

    always_ff @(posedge clk)
    begin
        pix.color <= color_d;
        pix.last  <= last;
    end

endmodule

//--- logic/pixel_scanner.sv
`timescale 1ns/1ps

module pixel_scanner (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   step,
    output banana_pkg::pixel_req_t req
);

    banana_pkg::coord_x_t x_q;
    banana_pkg::coord_y_t y_q;
    logic                 end_x;
    logic                 end_y;

    assign end_x = (x_q == banana_pkg::coord_x_t'(banana_pkg::DISPLAY_W - 1));
    assign end_y = (y_q == banana_pkg::coord_y_t'(banana_pkg::DISPLAY_H - 1));

    // Raster order, wraps back to the origin for the next frame
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            x_q <= '0;
            y_q <= '0;
        end
        else if (step)
        begin
            if (end_x)
            begin
                x_q <= '0;
                y_q <= end_y ? '0 : y_q + 1'b1;
            end
            else
                x_q <= x_q + 1'b1;
        end
    end

    assign req.x    = x_q;
    assign req.y    = y_q;
    assign req.last = end_x && end_y;

    a_x_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        x_q < banana_pkg::DISPLAY_W);

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module banana_frame_tb -f sim.f \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vbanana_frame_tb)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

//--- sim.f
logic/banana_pkg.sv
logic/frame_control.sv
logic/pixel_scanner.sv
logic/banana_span_table.sv
logic/pixel_colorizer.sv
logic/banana_frame_top.sv
test/banana_frame_tb.sv

//--- test/banana_frame_tb.sv
`timescale 1ns/1ps

module banana_frame_tb;

    localparam int FRAME_PIXELS = 6144;
    // 3 frames x 6144 pixels x about 5 cycles, plus margin
    localparam int TIMEOUT_CYCLES = 120000;
    localparam int HOLD_CYCLES = 20;

    logic                   clk;
    logic                   arst_n;
    logic                   frame_start;
    banana_pkg::coord_x_t   left_x;
    banana_pkg::coord_y_t   top_y;
    logic                   sliced;
    banana_pkg::rgb565_t    background;
    logic                   credit_return;
    logic                   pix_valid;
    banana_pkg::pixel_out_t pix;
    logic                   busy;

    // Scoreboard state
    banana_pkg::coord_x_t cur_left;
    banana_pkg::coord_y_t cur_top;
    logic                 cur_sliced;
    banana_pkg::rgb565_t  cur_bg;
    int                   sb_x;
    int                   sb_y;
    int                   received;
    int                   returned;
    int                   outstanding;
    int                   full_cycles;
    int                   cycle;
    int                   errors;
    int                   seed;
    int                   delay;
    int                   due_q[$];
    logic                 hold;
    logic                 in_box;
    logic                 check_en;
    int                   dx;
    int                   dy;
    banana_pkg::rgb565_t  exp_color;

    banana_frame_top uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .frame_start   (frame_start),
        .left_x        (left_x),
        .top_y         (top_y),
        .sliced        (sliced),
        .background    (background),
        .credit_return (credit_return),
        .pix_valid     (pix_valid),
        .pix           (pix),
        .busy          (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic value_error(input string name, input int got, input int expected);
        errors++;
        $display("error %0t ns: %s got %0h expected %0h", $time, name, got, expected);
    endtask

    // Known pixels of the sprite, by offset from its corner
    function automatic logic spot_lookup(
        input  logic                sl,
        input  int                  ox,
        input  int                  oy,
        input  banana_pkg::rgb565_t bg,
        output banana_pkg::rgb565_t color
    );
        color = bg;
        if (ox == 0 && oy == 12)
        begin
            color = banana_pkg::COLOR_BLACK;
            return 1'b1;
        end
        if (ox == 0 && oy == 11)
            return 1'b1;
        if (ox != 20)
            return 1'b0;
        if (!sl)
        begin
            case (oy)
                44, 47: color = banana_pkg::COLOR_YELLOW;
                52:     color = banana_pkg::COLOR_DARK_YELLOW;
                31:     color = banana_pkg::COLOR_BLACK;
                default: return 1'b0;
            endcase
        end
        else
        begin
            // Cut gap shows the background at dy 47
            case (oy)
                47: color = bg;
                44: color = banana_pkg::COLOR_PALE_YELLOW;
                40: color = banana_pkg::COLOR_YELLOW;
                52: color = banana_pkg::COLOR_DARK_YELLOW;
                default: return 1'b0;
            endcase
        end
        return 1'b1;
    endfunction

    always_comb
    begin
        dx = sb_x - int'(cur_left);
        dy = sb_y - int'(cur_top);
        in_box = (dx >= 0) && (dx < 52) && (dy >= 0) && (dy < 60);
        exp_color = cur_bg;
        check_en = 1'b1;
        if (in_box)
            check_en = spot_lookup(cur_sliced, dx, dy, cur_bg, exp_color);
    end

    ////////////////////////////////////////////////////////////
    // Sink, raster counters and timeout

    always @(posedge clk)
    begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the frames did not finish", cycle);
            $display("Test failed");
            $finish;
        end
        else if (!arst_n)
            credit_return <= 1'b0;
        else
        begin
            if (pix_valid)
            begin
                received++;
                delay = {$random(seed)} % 4;
                due_q.push_back(cycle + delay);
                if (sb_x == 95)
                begin
                    sb_x = 0;
                    sb_y = (sb_y == 63) ? 0 : sb_y + 1;
                end
                else
                    sb_x++;
            end
            if (credit_return)
                returned++;
            outstanding = received - returned;
            if (hold && outstanding == banana_pkg::CREDITS)
                full_cycles++;
            if (!hold && due_q.size() > 0 && due_q[0] <= cycle)
            begin
                void'(due_q.pop_front());
                credit_return <= 1'b1;
            end
            else
                credit_return <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    a_color: assert property (@(posedge clk) disable iff (!arst_n)
        (pix_valid && check_en) |-> (pix.color == exp_color))
        else value_error("pix.color", $sampled(pix.color), $sampled(exp_color));

    a_last_at_end: assert property (@(posedge clk) disable iff (!arst_n)
        pix_valid |-> (pix.last == (sb_x == 95 && sb_y == 63)))
        else value_error("pix.last", $sampled(pix.last), $sampled(sb_x == 95 && sb_y == 63));

    a_idle_after_last: assert property (@(posedge clk) disable iff (!arst_n)
        (pix_valid && pix.last) |=> !busy)
        else value_error("busy", $sampled(busy), 0);

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        outstanding <= banana_pkg::CREDITS)
        else value_error("outstanding", $sampled(outstanding), banana_pkg::CREDITS);

    a_no_pixel_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (outstanding == banana_pkg::CREDITS) |-> !pix_valid)
        else value_error("pix_valid", $sampled(pix_valid), 0);

    task automatic run_frame(
        input int                   idx,
        input string                name,
        input banana_pkg::coord_x_t lx,
        input banana_pkg::coord_y_t ty,
        input logic                 sl,
        input banana_pkg::rgb565_t  bg,
        input bit                   hold_credits
    );
        int err_before;
        int base;
        int full_before;
        @(negedge clk);
        err_before = errors;
        base = received;
        @(posedge clk);
        frame_start <= 1'b1;
        left_x      <= lx;
        top_y       <= ty;
        sliced      <= sl;
        background  <= bg;
        cur_left    <= lx;
        cur_top     <= ty;
        cur_sliced  <= sl;
        cur_bg      <= bg;
        @(posedge clk);
        frame_start <= 1'b0;
        if (hold_credits)
        begin
            repeat (200) @(posedge clk);
            full_before = full_cycles;
            hold <= 1'b1;
            repeat (HOLD_CYCLES) @(posedge clk);
            hold <= 1'b0;
            @(negedge clk);
            if (full_cycles == full_before)
            begin
                errors++;
                $display("credit hold never reached four outstanding pixels");
            end
        end
        @(negedge clk);
        while (busy)
            @(negedge clk);
        if (received - base != FRAME_PIXELS)
            value_error("pixel count", received - base, FRAME_PIXELS);
        $display("frame %0d %s at %0d,%0d: %0d pixels, %0d errors",
                 idx, name, lx, ty, received - base, errors - err_before);
    endtask

    initial
    begin
        arst_n        = 1'b0;
        frame_start   = 1'b0;
        left_x        = '0;
        top_y         = '0;
        sliced        = 1'b0;
        background    = '0;
        credit_return = 1'b0;
        hold          = 1'b0;
        cur_left      = '0;
        cur_top       = '0;
        cur_sliced    = 1'b0;
        cur_bg        = '0;
        sb_x          = 0;
        sb_y          = 0;
        received      = 0;
        returned      = 0;
        outstanding   = 0;
        full_cycles   = 0;
        cycle         = 0;
        errors        = 0;
        seed          = 32'h9761;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_frame(1, "whole", 7'd20, 6'd2, 1'b0, 16'h001F, 1'b1);
        run_frame(2, "sliced", 7'd20, 6'd2, 1'b1, 16'h07E0, 1'b0);
        // Sprite box runs past the right and bottom edges
        run_frame(3, "whole clipped", 7'd60, 6'd30, 1'b0, 16'h8410, 1'b0);

        $display("frames 3, pixels %0d, credits returned %0d, errors %0d",
                 received, returned, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
